//--- dsp_config.svh
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// data path and instruction word
`define DSP_DATA_W 16
`define DSP_INSN_W 24
`define DSP_FLAG_W 6

// program memory
`define DSP_PC_W 11
`define DSP_ROM_DEPTH 2048

// status register bits seen by the host
`define DSP_SR_RQM 15
`define DSP_SR_DRS 12

`endif

//--- dsp_insn_pkg.sv
`include "dsp_config.svh"

package dsp_insn_pkg;

  typedef union packed {
    struct packed {
      logic [1:0] cls;
      logic [1:0] pselect;
      logic [3:0] alu;
      logic       asl;
      logic [1:0] dpl;
      logic [3:0] dphm;
      logic       rpdcr;
      logic [3:0] src;
      logic [3:0] dst;
    } op;                                // OP and RT
    struct packed {
      logic [1:0]             cls;
      logic [`DSP_DATA_W-1:0] imm;
      logic [1:0]             pad;
      logic [3:0]             dst;
    } ld;
    struct packed {
      logic [1:0]           cls;
      logic [8:0]           brch;
      logic [`DSP_PC_W-1:0] na;
      logic [1:0]           pad;
    } jp;
  } dsp_insn_u;

  localparam logic [1:0] CLS_OP = 2'b00;
  localparam logic [1:0] CLS_RT = 2'b01;
  localparam logic [1:0] CLS_JP = 2'b10;
  localparam logic [1:0] CLS_LD = 2'b11;

  ////////////////////////////////////////////////////////////
  // alu operations

  localparam logic [3:0] ALU_NOP  = 4'h0;
  localparam logic [3:0] ALU_OR   = 4'h1;
  localparam logic [3:0] ALU_AND  = 4'h2;
  localparam logic [3:0] ALU_XOR  = 4'h3;
  localparam logic [3:0] ALU_SUB  = 4'h4;
  localparam logic [3:0] ALU_ADD  = 4'h5;
  localparam logic [3:0] ALU_SBB  = 4'h6;
  localparam logic [3:0] ALU_ADC  = 4'h7;
  localparam logic [3:0] ALU_DEC  = 4'h8;
  localparam logic [3:0] ALU_INC  = 4'h9;
  localparam logic [3:0] ALU_CMP  = 4'ha;  // one's complement
  localparam logic [3:0] ALU_SHR1 = 4'hb;
  localparam logic [3:0] ALU_SHL1 = 4'hc;  // rotate in carry of other acc
  localparam logic [3:0] ALU_SHL2 = 4'hd;
  localparam logic [3:0] ALU_SHL4 = 4'he;
  localparam logic [3:0] ALU_XCHG = 4'hf;

  ////////////////////////////////////////////////////////////
  // bus sources and destinations

  localparam logic [3:0] SRC_TRB  = 4'h0;
  localparam logic [3:0] SRC_A    = 4'h1;
  localparam logic [3:0] SRC_B    = 4'h2;
  localparam logic [3:0] SRC_TR   = 4'h3;
  localparam logic [3:0] SRC_SGN  = 4'h7;
  localparam logic [3:0] SRC_DR   = 4'h8;
  localparam logic [3:0] SRC_DRNF = 4'h9;  // DR, no RQM
  localparam logic [3:0] SRC_SR   = 4'ha;
  localparam logic [3:0] SRC_K    = 4'hd;
  localparam logic [3:0] SRC_L    = 4'he;

  localparam logic [3:0] DST_NON  = 4'h0;
  localparam logic [3:0] DST_A    = 4'h1;
  localparam logic [3:0] DST_B    = 4'h2;
  localparam logic [3:0] DST_TR   = 4'h3;
  localparam logic [3:0] DST_DR   = 4'h6;
  localparam logic [3:0] DST_K    = 4'ha;
  localparam logic [3:0] DST_KLR  = 4'hb;
  localparam logic [3:0] DST_L    = 4'hd;
  localparam logic [3:0] DST_TRB  = 4'he;

endpackage

//--- dsp_flag_pkg.sv
package dsp_flag_pkg;

  // positions in flags_a / flags_b
  localparam logic [2:0] FL_OV0 = 3'd0;
  localparam logic [2:0] FL_OV1 = 3'd1;
  localparam logic [2:0] FL_Z   = 3'd2;
  localparam logic [2:0] FL_C   = 3'd3;
  localparam logic [2:0] FL_S0  = 3'd4;
  localparam logic [2:0] FL_S1  = 3'd5;

  localparam logic [8:0] BR_JMP  = 9'b100_000_000;
  localparam logic [8:0] BR_NRQM = 9'b010_111_100;
  localparam logic [8:0] BR_RQM  = 9'b010_111_110;

  // flag branches are 010_fff_sv0, s picks B, v is the level that jumps
  localparam logic [2:0] BR_FLAG = 3'b010;
  localparam logic [2:0] BRF_C   = 3'b000;
  localparam logic [2:0] BRF_Z   = 3'b001;
  localparam logic [2:0] BRF_OV0 = 3'b010;
  localparam logic [2:0] BRF_OV1 = 3'b011;
  localparam logic [2:0] BRF_S0  = 3'b100;
  localparam logic [2:0] BRF_S1  = 3'b101;

endpackage

//--- dsp_pgm_rom.sv
`include "dsp_config.svh"

module dsp_pgm_rom (
  input  logic                   CLK,
  input  logic                   pgm_wr,
  input  logic [`DSP_PC_W-1:0]   pgm_addr,
  input  logic [`DSP_INSN_W-1:0] pgm_data,
  input  logic [`DSP_PC_W-1:0]   pc,
  output logic [`DSP_INSN_W-1:0] rom_data
);

  logic [`DSP_INSN_W-1:0] mem [`DSP_ROM_DEPTH];

  always_ff @(posedge CLK) begin
    if (pgm_wr) begin
      mem[pgm_addr] <= pgm_data;
    end
    rom_data <= mem[pc];  // ready by fetch, pc moves at store
  end

endmodule

//--- dsp_sequencer.sv
`include "dsp_config.svh"

module dsp_sequencer (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic [`DSP_INSN_W-1:0]  rom_data,
  input  logic [`DSP_FLAG_W-1:0]  flags_a,
  input  logic [`DSP_FLAG_W-1:0]  flags_b,
  input  logic                    rqm,
  output logic [`DSP_PC_W-1:0]    pc,
  output dsp_insn_pkg::dsp_insn_u insn,
  output logic                    ph_load,
  output logic                    ph_alu1,
  output logic                    ph_store,
  output logic                    ph_idle
);

  // one-hot: fetch load alu1 alu2 store next idle
  localparam int PH_FETCH = 0;
  localparam int PH_LOAD  = 1;
  localparam int PH_ALU1  = 2;
  localparam int PH_STORE = 4;
  localparam int PH_IDLE  = 6;

  logic [6:0]             phase;
  logic                   taken;
  logic [2:0]             fsel;
  logic                   fvalid;
  logic [`DSP_FLAG_W-1:0] fsrc;
  logic [8:0]             brch;

  assign brch = insn.jp.brch;
  assign fsrc = brch[2] ? flags_b : flags_a;

  always_comb begin
    fvalid = 1'b1;
    fsel   = dsp_flag_pkg::FL_C;
    case (brch[5:3])
      dsp_flag_pkg::BRF_C:   fsel = dsp_flag_pkg::FL_C;
      dsp_flag_pkg::BRF_Z:   fsel = dsp_flag_pkg::FL_Z;
      dsp_flag_pkg::BRF_OV0: fsel = dsp_flag_pkg::FL_OV0;
      dsp_flag_pkg::BRF_OV1: fsel = dsp_flag_pkg::FL_OV1;
      dsp_flag_pkg::BRF_S0:  fsel = dsp_flag_pkg::FL_S0;
      dsp_flag_pkg::BRF_S1:  fsel = dsp_flag_pkg::FL_S1;
      default:               fvalid = 1'b0;  // dp tests and rqm group
    endcase
  end

  ////////////////////////////////////////////////////////////
  // phase, fetch, branch, pc

  always_ff @(posedge CLK) begin
    if (RST) begin
      phase <= 7'b000_0001;  // fetch right after reset
      insn  <= '0;
      taken <= 1'b0;
      pc    <= '0;
    end else begin
      phase <= {phase[5:0], phase[6]};
      if (phase[PH_FETCH]) begin
        insn <= rom_data;
      end
      if (phase[PH_ALU1]) begin
        if (brch == dsp_flag_pkg::BR_JMP) begin
          taken <= 1'b1;
        end else if (brch == dsp_flag_pkg::BR_RQM) begin
          taken <= rqm;
        end else if (brch == dsp_flag_pkg::BR_NRQM) begin
          taken <= ~rqm;
        end else begin
          taken <= brch[8:6] == dsp_flag_pkg::BR_FLAG && fvalid && !brch[0]
                   && fsrc[fsel] == brch[1];
        end
      end
      if (phase[PH_STORE]) begin
        // return and call have no stack here, so they just step on
        if (insn.jp.cls == dsp_insn_pkg::CLS_JP && taken) begin
          pc <= insn.jp.na;
        end else begin
          pc <= pc + 1'b1;
        end
      end
    end
  end

  assign ph_load  = phase[PH_LOAD];
  assign ph_alu1  = phase[PH_ALU1];
  assign ph_store = phase[PH_STORE];
  assign ph_idle  = phase[PH_IDLE];

endmodule

//--- dsp_alu.sv
`include "dsp_config.svh"

module dsp_alu (
  input  logic                    CLK,
  input  logic                    RST,
  input  dsp_insn_pkg::dsp_insn_u insn,
  input  logic                    ph_alu1,
  input  logic                    ph_store,
  input  logic                    ph_idle,
  input  logic [`DSP_DATA_W-1:0]  idb,
  input  logic [`DSP_DATA_W-1:0]  m,
  input  logic [`DSP_DATA_W-1:0]  n,
  output logic [`DSP_DATA_W-1:0]  a,
  output logic [`DSP_DATA_W-1:0]  b,
  output logic [`DSP_FLAG_W-1:0]  flags_a,
  output logic [`DSP_FLAG_W-1:0]  flags_b
);

  localparam int MSB = `DSP_DATA_W - 1;

  logic [`DSP_DATA_W-1:0] acc [2];
  logic [`DSP_FLAG_W-1:0] fl [2];
  logic [`DSP_DATA_W-1:0] p;
  logic [`DSP_DATA_W-1:0] q;
  logic [`DSP_DATA_W-1:0] r;
  logic                   bus_wr;  // acc[asl] taken by the bus this insn
  logic                   is_op;
  logic                   sel;
  logic                   cin;
  logic                   ov;
  logic                   cwrap;

  assign is_op = ~insn.op.cls[1];  // OP or RT
  assign sel   = insn.op.asl;
  assign cin   = fl[~sel][dsp_flag_pkg::FL_C];
  // odd codes add, even codes subtract
  assign ov    = (q[MSB] ^ r[MSB]) & (insn.op.alu[0] ? ~(q[MSB] ^ p[MSB]) : (q[MSB] ^ p[MSB]));
  // adc / sbb with p all ones and carry in lands back on q
  assign cwrap = (insn.op.alu[3:1] == 3'b011) && cin && (r == q);

  ////////////////////////////////////////////////////////////
  // operands and result

  always_ff @(posedge CLK) begin
    if (ph_alu1 && is_op) begin
      q <= acc[sel];
      if (insn.op.alu[3:1] == 3'b100) begin
        p <= 16'h0001;  // inc / dec
      end else begin
        case (insn.op.pselect)
          2'b00:   p <= '0;  // no data ram
          2'b01:   p <= idb;
          2'b10:   p <= m;
          default: p <= n;
        endcase
      end
    end
    if (ph_store) begin
      case (insn.op.alu)
        dsp_insn_pkg::ALU_OR:   r <= q | p;
        dsp_insn_pkg::ALU_AND:  r <= q & p;
        dsp_insn_pkg::ALU_XOR:  r <= q ^ p;
        dsp_insn_pkg::ALU_SUB:  r <= q - p;
        dsp_insn_pkg::ALU_ADD:  r <= q + p;
        dsp_insn_pkg::ALU_SBB:  r <= q - p - cin;
        dsp_insn_pkg::ALU_ADC:  r <= q + p + cin;
        dsp_insn_pkg::ALU_DEC:  r <= q - p;
        dsp_insn_pkg::ALU_INC:  r <= q + p;
        dsp_insn_pkg::ALU_CMP:  r <= ~q;
        dsp_insn_pkg::ALU_SHR1: r <= {q[MSB], q[MSB:1]};
        dsp_insn_pkg::ALU_SHL1: r <= {q[MSB-1:0], cin};
        dsp_insn_pkg::ALU_SHL2: r <= {q[MSB-2:0], 2'b11};
        dsp_insn_pkg::ALU_SHL4: r <= {q[MSB-4:0], 4'b1111};
        dsp_insn_pkg::ALU_XCHG: r <= {q[7:0], q[MSB:8]};
        default:                r <= q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // accumulators and flags

  always_ff @(posedge CLK) begin
    if (RST) begin
      acc[0] <= '0;
      acc[1] <= '0;
      fl[0]  <= '0;
      fl[1]  <= '0;
      bus_wr <= 1'b0;
    end else begin
      // dst sits in the same bits for OP and LD
      if (ph_store && insn.op.cls != dsp_insn_pkg::CLS_JP) begin
        if (insn.op.dst == dsp_insn_pkg::DST_A) acc[0] <= idb;
        if (insn.op.dst == dsp_insn_pkg::DST_B) acc[1] <= idb;
      end
      if (ph_store) begin
        bus_wr <= is_op && insn.op.dst == (sel ? dsp_insn_pkg::DST_B : dsp_insn_pkg::DST_A);
      end
      if (ph_idle && is_op && insn.op.alu != dsp_insn_pkg::ALU_NOP) begin
        if (!bus_wr) acc[sel] <= r;
        fl[sel][dsp_flag_pkg::FL_Z]  <= (r == '0);
        fl[sel][dsp_flag_pkg::FL_S0] <= r[MSB];
        case (insn.op.alu)
          dsp_insn_pkg::ALU_SUB, dsp_insn_pkg::ALU_ADD,
          dsp_insn_pkg::ALU_SBB, dsp_insn_pkg::ALU_ADC,
          dsp_insn_pkg::ALU_DEC, dsp_insn_pkg::ALU_INC: begin
            fl[sel][dsp_flag_pkg::FL_C]   <= cwrap || (insn.op.alu[0] ? (r < q) : (r > q));
            fl[sel][dsp_flag_pkg::FL_OV0] <= ov;
            if (ov) begin  // s1 tracks the true sign over repeated overflow
              fl[sel][dsp_flag_pkg::FL_S1]  <= fl[sel][dsp_flag_pkg::FL_OV1] ^ ~r[MSB];
              fl[sel][dsp_flag_pkg::FL_OV1] <= ~fl[sel][dsp_flag_pkg::FL_OV1];
            end
          end
          dsp_insn_pkg::ALU_SHR1, dsp_insn_pkg::ALU_SHL1: begin
            fl[sel][dsp_flag_pkg::FL_C]   <= insn.op.alu[0] ? q[0] : q[MSB];
            fl[sel][dsp_flag_pkg::FL_OV0] <= 1'b0;
            fl[sel][dsp_flag_pkg::FL_OV1] <= 1'b0;
          end
          default: begin
            fl[sel][dsp_flag_pkg::FL_C]   <= 1'b0;
            fl[sel][dsp_flag_pkg::FL_OV0] <= 1'b0;
            fl[sel][dsp_flag_pkg::FL_OV1] <= 1'b0;
          end
        endcase
      end
    end
  end

  assign a       = acc[0];
  assign b       = acc[1];
  assign flags_a = fl[0];
  assign flags_b = fl[1];

endmodule

//--- dsp_mul.sv
`include "dsp_config.svh"

module dsp_mul (
  input  logic                    CLK,
  input  logic                    RST,
  input  dsp_insn_pkg::dsp_insn_u insn,
  input  logic                    ph_store,
  input  logic [`DSP_DATA_W-1:0]  idb,
  output logic [`DSP_DATA_W-1:0]  k,
  output logic [`DSP_DATA_W-1:0]  l,
  output logic [`DSP_DATA_W-1:0]  m,
  output logic [`DSP_DATA_W-1:0]  n
);

  logic signed [2*`DSP_DATA_W-1:0] prod;

  assign prod = $signed(k) * $signed(l);

  always_ff @(posedge CLK) begin
    if (RST) begin
      k <= '0;
      l <= '0;
    end else if (ph_store && insn.op.cls != dsp_insn_pkg::CLS_JP) begin
      case (insn.op.dst)
        dsp_insn_pkg::DST_K: k <= idb;
        dsp_insn_pkg::DST_L: l <= idb;
        dsp_insn_pkg::DST_KLR: begin
          k <= idb;
          l <= '0;  // data rom is gone, reads as zero
        end
        default: ;
      endcase
    end
  end

  // q15 split, one redundant sign bit dropped
  always_ff @(posedge CLK) begin
    m <= {prod[31], prod[29:15]};
    n <= {prod[14:0], 1'b0};
  end

endmodule

//--- dsp_bus.sv
`include "dsp_config.svh"

module dsp_bus (
  input  logic                    CLK,
  input  logic                    RST,
  input  dsp_insn_pkg::dsp_insn_u insn,
  input  logic                    ph_load,
  input  logic                    ph_store,
  input  logic [`DSP_DATA_W-1:0]  a,
  input  logic [`DSP_DATA_W-1:0]  b,
  input  logic [`DSP_DATA_W-1:0]  k,
  input  logic [`DSP_DATA_W-1:0]  l,
  input  logic [`DSP_FLAG_W-1:0]  flags_a,
  output logic [`DSP_DATA_W-1:0]  idb,
  output logic                    rqm,
  input  logic                    a0,
  input  logic [7:0]              di,
  input  logic                    host_wr,
  input  logic                    host_rd,
  output logic [7:0]              rd_data
);

  logic [`DSP_DATA_W-1:0] tr;
  logic [`DSP_DATA_W-1:0] trb;
  logic [`DSP_DATA_W-1:0] dr;
  logic [`DSP_DATA_W-1:0] sr;
  logic                   drs;
  logic                   host_dr;
  logic                   st_wr;  // non-JP store
  logic                   prog_dr;

  always_comb begin
    sr              = '0;
    sr[`DSP_SR_RQM] = rqm;
    sr[`DSP_SR_DRS] = drs;
  end

  assign st_wr   = ph_store && insn.op.cls != dsp_insn_pkg::CLS_JP;
  assign host_dr = (host_wr || host_rd) && !a0;
  assign prog_dr = (ph_store && !insn.op.cls[1] && insn.op.src == dsp_insn_pkg::SRC_DR)
                   || (st_wr && insn.op.dst == dsp_insn_pkg::DST_DR);

  ////////////////////////////////////////////////////////////
  // internal bus and program registers

  always_ff @(posedge CLK) begin
    if (ph_load) begin
      if (insn.ld.cls == dsp_insn_pkg::CLS_LD) begin
        idb <= insn.ld.imm;
      end else begin
        case (insn.op.src)
          dsp_insn_pkg::SRC_TRB:  idb <= trb;
          dsp_insn_pkg::SRC_A:    idb <= a;
          dsp_insn_pkg::SRC_B:    idb <= b;
          dsp_insn_pkg::SRC_TR:   idb <= tr;
          dsp_insn_pkg::SRC_SGN:  idb <= flags_a[dsp_flag_pkg::FL_S1] ? 16'h7fff : 16'h8000;
          dsp_insn_pkg::SRC_DR,
          dsp_insn_pkg::SRC_DRNF: idb <= dr;
          dsp_insn_pkg::SRC_SR:   idb <= sr;
          dsp_insn_pkg::SRC_K:    idb <= k;
          dsp_insn_pkg::SRC_L:    idb <= l;
          default:                idb <= '0;
        endcase
      end
    end
    if (st_wr && insn.op.dst == dsp_insn_pkg::DST_TR) tr <= idb;
    if (st_wr && insn.op.dst == dsp_insn_pkg::DST_TRB) trb <= idb;
  end

  ////////////////////////////////////////////////////////////
  // host side, byte-wise DR

  always_ff @(posedge CLK) begin
    if (RST) begin
      rqm <= 1'b0;
      drs <= 1'b0;
      dr  <= '0;
    end else begin
      if (host_dr) begin
        drs <= ~drs;
        if (drs) rqm <= 1'b0;  // second byte done
      end else if (prog_dr) begin
        rqm <= 1'b1;
      end
      if (host_wr && !a0) begin
        if (drs) begin
          dr[15:8] <= di;
        end else begin
          dr[7:0] <= di;
        end
      end else if (st_wr && insn.op.dst == dsp_insn_pkg::DST_DR) begin
        dr <= idb;
      end
    end
  end

  assign rd_data = a0 ? sr[15:8] : (drs ? dr[15:8] : dr[7:0]);

endmodule

//--- dsp_core.sv
`include "dsp_config.svh"

module dsp_core (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   pgm_wr,
  input  logic [`DSP_PC_W-1:0]   pgm_addr,
  input  logic [`DSP_INSN_W-1:0] pgm_data,
  input  logic                   a0,
  input  logic [7:0]             di,
  input  logic                   host_wr,
  input  logic                   host_rd,
  output logic [7:0]             rd_data
);

  dsp_insn_pkg::dsp_insn_u insn;
  logic [`DSP_PC_W-1:0]    pc;
  logic [`DSP_INSN_W-1:0]  rom_data;
  logic                    ph_load;
  logic                    ph_alu1;
  logic                    ph_store;
  logic                    ph_idle;
  logic [`DSP_FLAG_W-1:0]  flags_a;
  logic [`DSP_FLAG_W-1:0]  flags_b;
  logic                    rqm;
  logic [`DSP_DATA_W-1:0]  idb;
  logic [`DSP_DATA_W-1:0]  a;
  logic [`DSP_DATA_W-1:0]  b;
  logic [`DSP_DATA_W-1:0]  k;
  logic [`DSP_DATA_W-1:0]  l;
  logic [`DSP_DATA_W-1:0]  m;
  logic [`DSP_DATA_W-1:0]  n;

  dsp_pgm_rom u_rom (
    .CLK(CLK), .pgm_wr(pgm_wr), .pgm_addr(pgm_addr), .pgm_data(pgm_data),
    .pc(pc), .rom_data(rom_data)
  );

  dsp_sequencer u_seq (
    .CLK(CLK), .RST(RST), .rom_data(rom_data), .flags_a(flags_a), .flags_b(flags_b),
    .rqm(rqm), .pc(pc), .insn(insn), .ph_load(ph_load), .ph_alu1(ph_alu1),
    .ph_store(ph_store), .ph_idle(ph_idle)
  );

  // alu and multiplier both hang off idb
  dsp_alu u_alu (
    .CLK(CLK), .RST(RST), .insn(insn), .ph_alu1(ph_alu1), .ph_store(ph_store),
    .ph_idle(ph_idle), .idb(idb), .m(m), .n(n), .a(a), .b(b),
    .flags_a(flags_a), .flags_b(flags_b)
  );

  dsp_mul u_mul (
    .CLK(CLK), .RST(RST), .insn(insn), .ph_store(ph_store), .idb(idb),
    .k(k), .l(l), .m(m), .n(n)
  );

  dsp_bus u_bus (
    .CLK(CLK), .RST(RST), .insn(insn), .ph_load(ph_load), .ph_store(ph_store),
    .a(a), .b(b), .k(k), .l(l), .flags_a(flags_a), .idb(idb), .rqm(rqm),
    .a0(a0), .di(di), .host_wr(host_wr), .host_rd(host_rd), .rd_data(rd_data)
  );

endmodule

//--- tb_dsp_core.sv
`include "dsp_config.svh"

module tb_dsp_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PGM_LEN = 8;
  localparam int N_RUNS  = 1 + 16 + 24 + 1 + 1;
  localparam int WATCHDOG_CYCLES = N_RUNS * PGM_LEN * 7 * 4;

  localparam logic [15:0] C_NOT_TAKEN = 16'h0c00;
  localparam logic [15:0] C_TAKEN     = 16'h0c01;

  // flag branches under test and where the flag sits in the model's flag vector
  localparam logic [2:0] BR_SEL [4] = '{dsp_flag_pkg::BRF_C, dsp_flag_pkg::BRF_Z,
                                        dsp_flag_pkg::BRF_S0, dsp_flag_pkg::BRF_OV0};
  localparam logic [2:0] FLAG_POS [4] = '{dsp_flag_pkg::FL_C, dsp_flag_pkg::FL_Z,
                                          dsp_flag_pkg::FL_S0, dsp_flag_pkg::FL_OV0};

  logic                   CLK;
  logic                   RST;
  logic                   pgm_wr;
  logic [`DSP_PC_W-1:0]   pgm_addr;
  logic [`DSP_INSN_W-1:0] pgm_data;
  logic                   a0;
  logic [7:0]             di;
  logic                   host_wr;
  logic                   host_rd;
  logic [7:0]             rd_data;

  logic [`DSP_INSN_W-1:0] pgm [PGM_LEN];
  logic [31:0]            rng = 32'd59;
  int                     errors = 0;
  string                  name_q [$];
  logic [15:0]            got_q [$];
  logic [15:0]            exp_q [$];
  event                   check_ev;

  dsp_core DUT (
    .CLK(CLK), .RST(RST), .pgm_wr(pgm_wr), .pgm_addr(pgm_addr), .pgm_data(pgm_data),
    .a0(a0), .di(di), .host_wr(host_wr), .host_rd(host_rd), .rd_data(rd_data)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // instruction words and random numbers

  function automatic logic [23:0] op_word(input logic [1:0] psel, input logic [3:0] alu,
                                          input logic asl, input logic [3:0] src,
                                          input logic [3:0] dst);
    return {dsp_insn_pkg::CLS_OP, psel, alu, asl, 2'b00, 4'h0, 1'b0, src, dst};
  endfunction

  function automatic logic [23:0] move_word(input logic [3:0] src, input logic [3:0] dst);
    return op_word(2'b00, dsp_insn_pkg::ALU_NOP, 1'b0, src, dst);
  endfunction

  function automatic logic [23:0] ld_word(input logic [15:0] imm, input logic [3:0] dst);
    return {dsp_insn_pkg::CLS_LD, imm, 2'b00, dst};
  endfunction

  function automatic logic [23:0] jp_word(input logic [8:0] brch,
                                          input logic [`DSP_PC_W-1:0] na);
    return {dsp_insn_pkg::CLS_JP, brch, na, 2'b00};
  endfunction

  // jump when the flag of A equals level
  function automatic logic [8:0] flag_branch(input logic [2:0] fsel, input logic level);
    return {dsp_flag_pkg::BR_FLAG, fsel, 1'b0, level, 1'b0};
  endfunction

  function automatic logic [15:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng[15:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model, returns {flags, result} from clear flags

  function automatic logic [21:0] alu_ref(input logic [3:0] op, input logic [15:0] q,
                                          input logic [15:0] p_in, input logic cin);
    logic [16:0] wide;
    logic [15:0] pv;
    logic [15:0] r;
    logic [5:0]  f;
    logic        arith;
    logic        sub;
    logic        ov;
    f     = '0;
    wide  = '0;
    arith = 1'b0;
    sub   = 1'b0;
    r     = q;
    pv    = (op == dsp_insn_pkg::ALU_INC || op == dsp_insn_pkg::ALU_DEC) ? 16'h0001 : p_in;
    case (op)
      dsp_insn_pkg::ALU_OR:   r = q | pv;
      dsp_insn_pkg::ALU_AND:  r = q & pv;
      dsp_insn_pkg::ALU_XOR:  r = q ^ pv;
      dsp_insn_pkg::ALU_SUB, dsp_insn_pkg::ALU_DEC, dsp_insn_pkg::ALU_SBB: begin
        wide  = {1'b0, q} - {1'b0, pv} - (op == dsp_insn_pkg::ALU_SBB ? cin : 1'b0);
        arith = 1'b1;
        sub   = 1'b1;
      end
      dsp_insn_pkg::ALU_ADD, dsp_insn_pkg::ALU_INC, dsp_insn_pkg::ALU_ADC: begin
        wide  = {1'b0, q} + {1'b0, pv} + (op == dsp_insn_pkg::ALU_ADC ? cin : 1'b0);
        arith = 1'b1;
      end
      dsp_insn_pkg::ALU_CMP:  r = ~q;
      dsp_insn_pkg::ALU_SHR1: begin
        r = {q[15], q[15:1]};
        f[dsp_flag_pkg::FL_C] = q[0];
      end
      dsp_insn_pkg::ALU_SHL1: begin
        r = {q[14:0], cin};
        f[dsp_flag_pkg::FL_C] = q[15];
      end
      dsp_insn_pkg::ALU_SHL2: r = {q[13:0], 2'b11};
      dsp_insn_pkg::ALU_SHL4: r = {q[11:0], 4'hf};
      dsp_insn_pkg::ALU_XCHG: r = {q[7:0], q[15:8]};
      default:                r = q;
    endcase
    if (arith) begin
      r  = wide[15:0];
      ov = (r[15] != q[15]) && (sub ? (q[15] != pv[15]) : (q[15] == pv[15]));
      f[dsp_flag_pkg::FL_C]   = wide[16];  // carry out, or borrow
      f[dsp_flag_pkg::FL_OV0] = ov;
      f[dsp_flag_pkg::FL_OV1] = ov;
      f[dsp_flag_pkg::FL_S1]  = ov & ~r[15];
    end
    f[dsp_flag_pkg::FL_Z]  = (r == 16'h0);
    f[dsp_flag_pkg::FL_S0] = r[15];
    return {f, r};
  endfunction

  ////////////////////////////////////////////////////////////
  // program load and host port

  task automatic clear_program();
    for (int i = 0; i < PGM_LEN; i++) begin
      pgm[i] = jp_word(dsp_flag_pkg::BR_JMP, `DSP_PC_W'(i));  // spin in place
    end
  endtask

  task automatic run_program();
    @(posedge CLK);
    #2;
    RST = 1'b1;
    for (int i = 0; i < PGM_LEN; i++) begin
      pgm_wr   = 1'b1;
      pgm_addr = `DSP_PC_W'(i);
      pgm_data = pgm[i];
      @(posedge CLK);
      #2;
    end
    pgm_wr = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    RST = 1'b0;
  endtask

  task automatic host_read(input logic sel, output logic [7:0] data);
    @(posedge CLK);
    #2;
    a0      = sel;
    host_rd = 1'b1;
    #8;
    data = rd_data;  // mid cycle
    @(posedge CLK);
    #2;
    host_rd = 1'b0;
  endtask

  task automatic host_write(input logic sel, input logic [7:0] data);
    @(posedge CLK);
    #2;
    a0      = sel;
    di      = data;
    host_wr = 1'b1;
    @(posedge CLK);
    #2;
    host_wr = 1'b0;
  endtask

  task automatic wait_rqm();
    logic [7:0] sr_b;
    sr_b = 8'h00;
    while (!sr_b[`DSP_SR_RQM-8]) begin
      host_read(1'b1, sr_b);
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    -> check_ev;
  endtask

  // low byte first, then RQM must be gone
  task automatic read_dr(output logic [15:0] val);
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] sr_b;
    wait_rqm();
    host_read(1'b0, lo);
    host_read(1'b0, hi);
    val = {hi, lo};
    host_read(1'b1, sr_b);
    check_value("rqm", {15'h0, sr_b[`DSP_SR_RQM-8]}, 16'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_ld_passthrough();
    logic [15:0] imm;
    logic [15:0] got;
    imm = next_rand();
    clear_program();
    pgm[0] = ld_word(imm, dsp_insn_pkg::DST_A);
    pgm[1] = move_word(dsp_insn_pkg::SRC_A, dsp_insn_pkg::DST_DR);
    run_program();
    read_dr(got);
    check_value("dr immediate", got, imm);
  endtask

  task automatic test_alu_ops();
    logic [15:0] q;
    logic [15:0] p;
    logic [21:0] res;
    logic [15:0] got;
    logic [3:0]  alu;
    for (int op = 0; op < 16; op++) begin
      alu = 4'(op);
      q   = next_rand();
      p   = next_rand();
      res = alu_ref(alu, q, p, 1'b0);  // B flags stay clear, so no carry in
      clear_program();
      pgm[0] = ld_word(q, dsp_insn_pkg::DST_A);
      pgm[1] = ld_word(p, dsp_insn_pkg::DST_TR);
      pgm[2] = op_word(2'b01, alu, 1'b0, dsp_insn_pkg::SRC_TR, dsp_insn_pkg::DST_NON);
      pgm[3] = move_word(dsp_insn_pkg::SRC_A, dsp_insn_pkg::DST_DR);
      run_program();
      read_dr(got);
      check_value($sformatf("dr alu op %h", alu), got, res[15:0]);
    end
  endtask

  task automatic test_flag_branches();
    logic [15:0] q;
    logic [15:0] p;
    logic [21:0] res;
    logic [3:0]  op;
    logic [15:0] got;
    for (int round = 0; round < 3; round++) begin
      for (int t = 0; t < 8; t++) begin
        op = (t < 4) ? dsp_insn_pkg::ALU_ADD : dsp_insn_pkg::ALU_SUB;
        q  = next_rand();
        p  = (round == 1) ? q : next_rand();
        if (round == 2) begin
          q = q | 16'h8000;  // both negative
          p = p | 16'h8000;
        end
        res = alu_ref(op, q, p, 1'b0);
        clear_program();
        pgm[0] = ld_word(q, dsp_insn_pkg::DST_A);
        pgm[1] = ld_word(p, dsp_insn_pkg::DST_TR);
        pgm[2] = op_word(2'b01, op, 1'b0, dsp_insn_pkg::SRC_TR, dsp_insn_pkg::DST_NON);
        pgm[3] = jp_word(flag_branch(BR_SEL[t % 4], 1'b1), `DSP_PC_W'(6));
        pgm[4] = ld_word(C_NOT_TAKEN, dsp_insn_pkg::DST_DR);
        pgm[6] = ld_word(C_TAKEN, dsp_insn_pkg::DST_DR);
        run_program();
        read_dr(got);
        check_value($sformatf("dr flag branch %0d.%0d", round, t), got,
                    res[16 + FLAG_POS[t % 4]] ? C_TAKEN : C_NOT_TAKEN);
      end
    end
  endtask

  task automatic test_multiplier();
    logic [15:0]        kv;
    logic [15:0]        lv;
    logic signed [31:0] prod;
    logic [15:0]        got;
    kv   = next_rand();
    lv   = next_rand();
    prod = $signed(kv) * $signed(lv);
    clear_program();
    pgm[0] = ld_word(kv, dsp_insn_pkg::DST_K);
    pgm[1] = ld_word(lv, dsp_insn_pkg::DST_L);
    pgm[2] = op_word(2'b10, dsp_insn_pkg::ALU_OR, 1'b0, dsp_insn_pkg::SRC_A,
                     dsp_insn_pkg::DST_NON);  // A = 0 | M
    pgm[3] = move_word(dsp_insn_pkg::SRC_A, dsp_insn_pkg::DST_DR);
    pgm[4] = jp_word(dsp_flag_pkg::BR_RQM, `DSP_PC_W'(4));
    pgm[5] = op_word(2'b11, dsp_insn_pkg::ALU_OR, 1'b1, dsp_insn_pkg::SRC_A,
                     dsp_insn_pkg::DST_NON);  // B = 0 | N
    pgm[6] = move_word(dsp_insn_pkg::SRC_B, dsp_insn_pkg::DST_DR);
    run_program();
    read_dr(got);
    check_value("dr m", got, {prod[31], prod[29:15]});
    read_dr(got);
    check_value("dr n", got, {prod[14:0], 1'b0});
  endtask

  task automatic test_host_write();
    logic [15:0] hv;
    logic [15:0] got;
    logic [21:0] res;
    hv  = next_rand();
    res = alu_ref(dsp_insn_pkg::ALU_INC, hv, 16'h0, 1'b0);
    clear_program();
    pgm[0] = move_word(dsp_insn_pkg::SRC_DR, dsp_insn_pkg::DST_NON);  // ask for a word
    pgm[1] = jp_word(dsp_flag_pkg::BR_RQM, `DSP_PC_W'(1));
    pgm[2] = move_word(dsp_insn_pkg::SRC_DRNF, dsp_insn_pkg::DST_A);
    pgm[3] = op_word(2'b00, dsp_insn_pkg::ALU_INC, 1'b0, dsp_insn_pkg::SRC_A,
                     dsp_insn_pkg::DST_NON);
    pgm[4] = move_word(dsp_insn_pkg::SRC_A, dsp_insn_pkg::DST_DR);
    run_program();
    wait_rqm();
    host_write(1'b0, hv[7:0]);
    host_write(1'b0, hv[15:8]);
    read_dr(got);
    check_value("dr host word plus one", got, res[15:0]);
  endtask

  ////////////////////////////////////////////////////////////
  // compare, watchdog, main

  initial begin : compare
    string       nm;
    logic [15:0] g;
    logic [15:0] e;
    forever begin
      @(check_ev);
      while (got_q.size() > 0) begin
        nm = name_q.pop_front();
        g  = got_q.pop_front();
        e  = exp_q.pop_front();
        assert (g == e) else begin
          errors++;
          $display("FAIL %s: got 0x%h, expected 0x%h", nm, g, e);
          $display("tests failed");
          $fatal(1, "value mismatch");
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: the core never raised RQM");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    RST      = 1'b1;
    pgm_wr   = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    a0       = 1'b1;
    di       = 8'h00;
    host_wr  = 1'b0;
    host_rd  = 1'b0;
    repeat (4) @(posedge CLK);
    test_ld_passthrough();
    test_alu_ops();
    test_flag_branches();
    test_multiplier();
    test_host_write();
    #1;
    if (errors == 0 && got_q.size() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
dsp_insn_pkg.sv
dsp_flag_pkg.sv
dsp_pgm_rom.sv
dsp_sequencer.sv
dsp_alu.sv
dsp_mul.sv
dsp_bus.sv
dsp_core.sv
tb_dsp_core.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f src.f --top-module tb_dsp_core -o tb_dsp_core \
  && ./obj_dir/tb_dsp_core | tee sim.log
grep -qx "all tests passed" sim.log && echo "simulation ok" || { echo "simulation bad"; exit 1; }
